//--- src/sifhPkg.sv
`default_nettype none

package sifhPkg;

    // hit time code and histogram sizes
    localparam int CODE_W = 10;
    localparam int BIN_W = 4;
    localparam int NUM_BINS = 16;
    localparam int COUNT_W = 8;

    // hits per phase, in or out of the window
    localparam int HITS_PER_PHASE = 32;
    localparam int HIT_CNT_W = $clog2(HITS_PER_PHASE);

    // coarse bin spans 64 codes
    localparam int COARSE_SHIFT = 6;
    // fine bin spans 4 codes inside the window
    localparam int FINE_SHIFT = 2;
    // window width in codes, one coarse bin
    localparam int WINDOW_SPAN = NUM_BINS << FINE_SHIFT;

    typedef enum logic {
        phCoarse = 1'b0,
        phFine   = 1'b1
    } phaseT;

    typedef enum logic [2:0] {
        stIdle    = 3'd0,
        stCollect = 3'd1,
        stDrain   = 3'd2,
        stScan    = 3'd3,
        stFinish  = 3'd4
    } ctrlStateT;

endpackage

`default_nettype wire

//--- src/binMapper.sv
`timescale 1ns/1ps
`default_nettype none

module binMapper (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire                          wrEn,
    input  wire  [sifhPkg::CODE_W-1:0]   roughData,
    input  wire                          acqReady,
    input  wire  sifhPkg::phaseT         phase,
    input  wire  [sifhPkg::CODE_W-1:0]   windowBase,
    output logic                         hitValid,
    output logic [sifhPkg::BIN_W-1:0]    hitBin
);
    import sifhPkg::*;

    logic [CODE_W-1:0] offset;
    logic              inWindow;
    logic              accept;
    logic [BIN_W-1:0]  coarseBin;
    logic [BIN_W-1:0]  fineBin;

    // distance from the lower window edge, wraps when below it
    assign offset = roughData - windowBase;
    assign inWindow = (roughData >= windowBase) && (offset < CODE_W'(WINDOW_SPAN));

    // hits only count while the controller collects
    assign accept = wrEn && acqReady;

    // top bits of the code pick the coarse bin
    assign coarseBin = BIN_W'(roughData >> COARSE_SHIFT);
    // offset / 4 inside the window
    assign fineBin = BIN_W'(offset >> FINE_SHIFT);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hitValid <= 1'b0;
        end else begin
            // fine hits outside the window are dropped here
            hitValid <= accept && ((phase == phCoarse) || inWindow);
        end
    end

    // bin index is payload, no reset
    always_ff @(posedge clk) begin
        if (accept) begin
            hitBin <= (phase == phCoarse) ? coarseBin : fineBin;
        end
    end

endmodule

`default_nettype wire

//--- src/histogramRam.sv
`timescale 1ns/1ps
`default_nettype none

module histogramRam (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire                          hitValid,
    input  wire  [sifhPkg::BIN_W-1:0]    hitBin,
    input  wire                          clearAll,
    input  wire                          scanStart,
    output logic                         scanValid,
    output logic [sifhPkg::BIN_W-1:0]    scanBin,
    output logic [sifhPkg::COUNT_W-1:0]  scanCount
);
    import sifhPkg::*;

    logic [COUNT_W-1:0] binCount [NUM_BINS];
    logic               binFull;
    logic               lastBin;

    // counter already at 255, stays there
    assign binFull = (binCount[hitBin] == {COUNT_W{1'b1}});
    assign lastBin = (scanBin == BIN_W'(NUM_BINS - 1));

    // counter array, cleared by the controller before each phase
    always_ff @(posedge clk) begin
        if (clearAll) begin
            for (int i = 0; i < NUM_BINS; i++) begin
                binCount[i] <= '0;
            end
        end else if (hitValid && !binFull) begin
            binCount[hitBin] <= binCount[hitBin] + 1'b1;
        end
    end

    // readout walks bins 0..15, one per cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            scanValid <= 1'b0;
            scanBin <= '0;
        end else if (scanStart) begin
            scanValid <= 1'b1;
            scanBin <= '0;
        end else if (scanValid) begin
            if (lastBin) begin
                scanValid <= 1'b0;
            end
            scanBin <= scanBin + 1'b1;
        end
    end

    // count of the bin currently on the scan port
    assign scanCount = binCount[scanBin];

    // drain must have emptied the mapper pipeline before the scan
    assert property (@(posedge clk) disable iff (!rstN)
        scanValid |-> !hitValid)
        else $error("hitValid during histogram scan");

    // a late hit must not land on a cleared histogram
    assert property (@(posedge clk) disable iff (!rstN)
        !(clearAll && hitValid))
        else $error("clearAll and hitValid in the same cycle");

endmodule

`default_nettype wire

//--- src/peakSearch.sv
`timescale 1ns/1ps
`default_nettype none

module peakSearch (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire                          scanValid,
    input  wire  [sifhPkg::BIN_W-1:0]    scanBin,
    input  wire  [sifhPkg::COUNT_W-1:0]  scanCount,
    output logic                         peakDone,
    output logic [sifhPkg::BIN_W-1:0]    peakBin
);
    import sifhPkg::*;

    logic [COUNT_W-1:0] maxCount;
    logic [BIN_W-1:0]   maxBin;
    logic               scanValidQ;
    logic               firstBeat;
    logic               lastBeat;
    logic               takeNew;

    assign firstBeat = scanValid && !scanValidQ;
    assign lastBeat = scanValid && (scanBin == BIN_W'(NUM_BINS - 1));

    // strictly greater only, so equal counts keep the lower bin
    assign takeNew = firstBeat || (scanCount > maxCount);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            scanValidQ <= 1'b0;
            peakDone <= 1'b0;
        end else begin
            scanValidQ <= scanValid;
            peakDone <= lastBeat;
        end
    end

    // running maximum over the scan
    always_ff @(posedge clk) begin
        if (scanValid && takeNew) begin
            maxCount <= scanCount;
            maxBin <= scanBin;
        end
    end

    // result held until the end of the next scan
    always_ff @(posedge clk) begin
        if (lastBeat) begin
            peakBin <= takeNew ? scanBin : maxBin;
        end
    end

    // readout must be a gapless 0..15 walk
    assert property (@(posedge clk) disable iff (!rstN)
        (scanValid && $past(scanValid)) |-> (scanBin == BIN_W'($past(scanBin) + 1'b1)))
        else $error("scanBin out of order");

endmodule

`default_nettype wire

//--- src/histogramControl.sv
`timescale 1ns/1ps
`default_nettype none

module histogramControl (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire                          start,
    input  wire                          wrEn,
    input  wire                          peakDone,
    input  wire  [sifhPkg::BIN_W-1:0]    peakBin,
    output logic                         acqReady,
    output sifhPkg::phaseT               phase,
    output logic [sifhPkg::CODE_W-1:0]   windowBase,
    output logic                         clearAll,
    output logic                         scanStart,
    output logic [sifhPkg::BIN_W-1:0]    peakCoarse,
    output logic [sifhPkg::CODE_W-1:0]   peakCode,
    output logic                         resultValid
);
    import sifhPkg::*;

    ctrlStateT            state;
    logic [HIT_CNT_W-1:0] hitCnt;
    logic                 drainWait;
    logic                 hitSeen;
    logic                 lastHit;

    assign hitSeen = wrEn && acqReady;
    assign lastHit = (hitCnt == HIT_CNT_W'(HITS_PER_PHASE - 1));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stIdle;
            phase <= phCoarse;
            acqReady <= 1'b0;
            clearAll <= 1'b0;
            scanStart <= 1'b0;
            resultValid <= 1'b0;
            hitCnt <= '0;
            drainWait <= 1'b0;
            peakCoarse <= '0;
            windowBase <= '0;
            peakCode <= '0;
        end else begin
            // single-cycle pulses
            clearAll <= 1'b0;
            scanStart <= 1'b0;
            resultValid <= 1'b0;
            case (state)
                stIdle: begin
                    if (start) begin
                        clearAll <= 1'b1;
                        phase <= phCoarse;
                        acqReady <= 1'b1;
                        hitCnt <= '0;
                        state <= stCollect;
                    end
                end
                stCollect: begin
                    // out-of-window fine hits count here as well
                    if (hitSeen) begin
                        if (lastHit) begin
                            acqReady <= 1'b0;
                            hitCnt <= '0;
                            drainWait <= 1'b0;
                            state <= stDrain;
                        end else begin
                            hitCnt <= hitCnt + 1'b1;
                        end
                    end
                end
                stDrain: begin
                    // two cycles, last mapper hit lands in the RAM meanwhile
                    if (!drainWait) begin
                        drainWait <= 1'b1;
                        scanStart <= 1'b1;
                    end else begin
                        state <= stScan;
                    end
                end
                stScan: begin
                    if (peakDone) begin
                        if (phase == phCoarse) begin
                            // window = coarse peak bin * 64
                            peakCoarse <= peakBin;
                            windowBase <= CODE_W'(peakBin) << COARSE_SHIFT;
                            clearAll <= 1'b1;
                            phase <= phFine;
                            acqReady <= 1'b1;
                            state <= stCollect;
                        end else begin
                            peakCode <= windowBase + (CODE_W'(peakBin) << FINE_SHIFT);
                            resultValid <= 1'b1;
                            state <= stFinish;
                        end
                    end
                end
                stFinish: begin
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // hits only accepted while collecting
    assert property (@(posedge clk) disable iff (!rstN)
        acqReady |-> (state == stCollect))
        else $error("acqReady outside collect state");

endmodule

`default_nettype wire

//--- src/sifhTop.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire                          start,
    input  wire                          wrEn,
    input  wire  [sifhPkg::CODE_W-1:0]   roughData,
    output logic                         acqReady,
    output logic [sifhPkg::BIN_W-1:0]    peakCoarse,
    output logic [sifhPkg::CODE_W-1:0]   peakCode,
    output logic                         resultValid
);
    import sifhPkg::*;

    // controller to mapper
    phaseT              phase;
    logic [CODE_W-1:0]  windowBase;

    // mapper to histogram
    logic               hitValid;
    logic [BIN_W-1:0]   hitBin;

    // controller to histogram
    logic               clearAll;
    logic               scanStart;

    // histogram readout
    logic               scanValid;
    logic [BIN_W-1:0]   scanBin;
    logic [COUNT_W-1:0] scanCount;

    // peak back to the controller
    logic               peakDone;
    logic [BIN_W-1:0]   peakBin;

    binMapper uBinMapper (
        .clk        (clk),
        .rstN       (rstN),
        .wrEn       (wrEn),
        .roughData  (roughData),
        .acqReady   (acqReady),
        .phase      (phase),
        .windowBase (windowBase),
        .hitValid   (hitValid),
        .hitBin     (hitBin)
    );

    histogramRam uHistogramRam (
        .clk       (clk),
        .rstN      (rstN),
        .hitValid  (hitValid),
        .hitBin    (hitBin),
        .clearAll  (clearAll),
        .scanStart (scanStart),
        .scanValid (scanValid),
        .scanBin   (scanBin),
        .scanCount (scanCount)
    );

    peakSearch uPeakSearch (
        .clk       (clk),
        .rstN      (rstN),
        .scanValid (scanValid),
        .scanBin   (scanBin),
        .scanCount (scanCount),
        .peakDone  (peakDone),
        .peakBin   (peakBin)
    );

    histogramControl uHistogramControl (
        .clk         (clk),
        .rstN        (rstN),
        .start       (start),
        .wrEn        (wrEn),
        .peakDone    (peakDone),
        .peakBin     (peakBin),
        .acqReady    (acqReady),
        .phase       (phase),
        .windowBase  (windowBase),
        .clearAll    (clearAll),
        .scanStart   (scanStart),
        .peakCoarse  (peakCoarse),
        .peakCode    (peakCode),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

//--- testbench/sifhTb.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTb;
    import sifhPkg::*;

    localparam int NUM_RANDOM = 8;
    // clustered, window, ties, 3 x repeated code, random
    localparam int NUM_RUNS = 6 + NUM_RANDOM;
    localparam int CLK_NS = 100;
    // two phases of at most 100 cycles per run, plus reset and slack
    localparam longint TIMEOUT_NS = longint'(NUM_RUNS * 2 * 100 + 200) * CLK_NS;
    localparam int SAT_MAX = (1 << COUNT_W) - 1;

    logic              clk = 1'b0;
    logic              rstN;
    logic              start;
    logic              wrEn;
    logic [CODE_W-1:0] roughData;
    logic              acqReady;
    logic [BIN_W-1:0]  peakCoarse;
    logic [CODE_W-1:0] peakCode;
    logic              resultValid;

    // hit lists of the current measurement
    logic [CODE_W-1:0] coarseHits [HITS_PER_PHASE];
    logic [CODE_W-1:0] fineHits [HITS_PER_PHASE];
    // expected {peakCoarse, peakCode}, one per started run
    logic [BIN_W+CODE_W-1:0] expQ [$];
    int nStarted = 0;
    int nChecked = 0;

    sifhTop i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .start       (start),
        .wrEn        (wrEn),
        .roughData   (roughData),
        .acqReady    (acqReady),
        .peakCoarse  (peakCoarse),
        .peakCode    (peakCode),
        .resultValid (resultValid)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // model of both phases: bin shifts, window test, saturation, lowest bin on ties
    function automatic logic [BIN_W+CODE_W-1:0] refResult();
        int cnt [NUM_BINS];
        int cBin;
        int fBin;
        int base;
        int code;
        int bin;
        for (int b = 0; b < NUM_BINS; b++) begin
            cnt[b] = 0;
        end
        for (int i = 0; i < HITS_PER_PHASE; i++) begin
            code = coarseHits[i];
            bin = code >> COARSE_SHIFT;
            if (cnt[bin] < SAT_MAX) begin
                cnt[bin]++;
            end
        end
        cBin = 0;
        for (int b = 1; b < NUM_BINS; b++) begin
            if (cnt[b] > cnt[cBin]) begin
                cBin = b;
            end
        end
        // window is one coarse bin wide
        base = cBin << COARSE_SHIFT;
        for (int b = 0; b < NUM_BINS; b++) begin
            cnt[b] = 0;
        end
        for (int i = 0; i < HITS_PER_PHASE; i++) begin
            code = fineHits[i];
            if (code >= base && code < base + (NUM_BINS << FINE_SHIFT)) begin
                bin = (code - base) >> FINE_SHIFT;
                if (cnt[bin] < SAT_MAX) begin
                    cnt[bin]++;
                end
            end
        end
        fBin = 0;
        for (int b = 1; b < NUM_BINS; b++) begin
            if (cnt[b] > cnt[fBin]) begin
                fBin = b;
            end
        end
        return {BIN_W'(cBin), CODE_W'(base + (fBin << FINE_SHIFT))};
    endfunction

    // waits for acqReady, then 32 hits, optionally with random idle cycles
    task automatic sendHits(input bit fine, input bit gaps);
        int idx;
        idx = 0;
        @(negedge clk);
        while (!acqReady) begin
            @(negedge clk);
        end
        while (idx < HITS_PER_PHASE) begin
            @(posedge clk);
            if (gaps && ($urandom % 4 == 0)) begin
                wrEn <= 1'b0;
            end else begin
                wrEn <= 1'b1;
                roughData <= fine ? fineHits[idx] : coarseHits[idx];
                idx++;
            end
        end
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    // strobes while acqReady is low, must not reach the histogram
    task automatic sendJunk(input int n, input logic [CODE_W-1:0] code);
        repeat (n) begin
            @(posedge clk);
            wrEn <= 1'b1;
            roughData <= code;
            // strobe is sampled together with this cycle's acqReady
            @(negedge clk);
            assert (acqReady == 1'b0) else begin
                $display("ERROR acqReady: got 0x%h, expected 0x0", acqReady);
                $display("TESTS FAILED");
                $fatal(1);
            end
        end
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    task automatic runMeasurement(input bit gaps);
        int target;
        logic [BIN_W+CODE_W-1:0] expVal;
        logic [CODE_W-1:0] junkFine;
        target = nStarted + 1;
        nStarted = target;
        expVal = refResult();
        expQ.push_back(expVal);
        // top fine bin of the expected window, read last by the scan
        junkFine = {expVal[BIN_W+CODE_W-1:CODE_W], 6'h3f};
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        sendHits(1'b0, gaps);
        // junk ends well before the 19-cycle drain and scan
        // top coarse bin, also read last
        sendJunk(12, {CODE_W{1'b1}});
        sendHits(1'b1, gaps);
        sendJunk(12, junkFine);
        while (nChecked < target) begin
            @(negedge clk);
        end
    endtask

    // random cluster, fine hits partly spill past the expected window
    task automatic makeRandom();
        logic [CODE_W-1:0] center;
        logic [CODE_W-1:0] base;
        logic [BIN_W+CODE_W-1:0] coarseRef;
        center = CODE_W'($urandom);
        for (int i = 0; i < HITS_PER_PHASE; i++) begin
            coarseHits[i] = center + CODE_W'($urandom % 48) - CODE_W'(24);
        end
        coarseRef = refResult();
        base = {coarseRef[BIN_W+CODE_W-1:CODE_W], 6'b0};
        for (int i = 0; i < HITS_PER_PHASE; i++) begin
            fineHits[i] = base + CODE_W'($urandom % 80) - CODE_W'(8);
        end
    endtask

    // compare at the falling edge, outputs settled
    initial begin
        logic [BIN_W+CODE_W-1:0] exp;
        forever begin
            @(negedge clk);
            if (resultValid) begin
                assert (expQ.size() > 0) else begin
                    $display("a result arrived with no measurement running");
                    $display("TESTS FAILED");
                    $fatal(1);
                end
                exp = expQ.pop_front();
                assert (peakCoarse == exp[BIN_W+CODE_W-1:CODE_W]) else begin
                    $display("ERROR peakCoarse: got 0x%h, expected 0x%h",
                        peakCoarse, exp[BIN_W+CODE_W-1:CODE_W]);
                    $display("TESTS FAILED");
                    $fatal(1);
                end
                assert (peakCode == exp[CODE_W-1:0]) else begin
                    $display("ERROR peakCode: got 0x%h, expected 0x%h",
                        peakCode, exp[CODE_W-1:0]);
                    $display("TESTS FAILED");
                    $fatal(1);
                end
                nChecked++;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("the run timed out before all measurements finished");
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        rstN = 1'b0;
        start = 1'b0;
        wrEn = 1'b0;
        roughData = '0;
        void'($urandom(32'h91c1));
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        repeat (2) @(posedge clk);
        // cluster around 90, coarse bin 1
        for (int i = 0; i < HITS_PER_PHASE; i++) begin
            coarseHits[i] = CODE_W'(86 + i % 9);
            fineHits[i] = CODE_W'(88 + i % 5);
        end
        runMeasurement(1'b0);
        // window 256..319, two thirds of fine hits land outside it
        for (int i = 0; i < HITS_PER_PHASE; i++) begin
            coarseHits[i] = CODE_W'(300 + i % 8);
            fineHits[i] = (i % 3 == 0) ? CODE_W'(200) : (i % 3 == 1) ? CODE_W'(500) : CODE_W'(270);
        end
        runMeasurement(1'b1);
        // 16/16 ties, higher bins sent first
        for (int i = 0; i < HITS_PER_PHASE; i++) begin
            coarseHits[i] = (i < 16) ? CODE_W'(700) : CODE_W'(100);
            fineHits[i] = (i < 16) ? CODE_W'(120) : CODE_W'(70);
        end
        runMeasurement(1'b0);
        // one repeated code, top coarse bin
        for (int i = 0; i < HITS_PER_PHASE; i++) begin
            coarseHits[i] = CODE_W'(1000);
            fineHits[i] = CODE_W'(1000);
        end
        repeat (3) runMeasurement(1'b1);
        repeat (NUM_RANDOM) begin
            makeRandom();
            runMeasurement(1'b1);
        end
        if (nChecked == NUM_RUNS && expQ.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- files.f
src/sifhPkg.sv
src/binMapper.sv
src/histogramRam.sv
src/peakSearch.sv
src/histogramControl.sv
src/sifhTop.sv
testbench/sifhTb.sv
